// File: hw/pmp_cfg.svh
// Build-time constants of the PMP unit: region count and CSR addresses
// Included by the package and by every module that decodes CSRs

`ifndef PMP_CFG_SVH
`define PMP_CFG_SVH

// Region count and the pmpcfg words that hold them, four entries per word
`define PMP_NUM_REGIONS   8
`define PMP_NUM_CFG_WORDS 2

// CSR addresses
`define PMP_CSR_PMPCFG0  12'h3A0
`define PMP_CSR_PMPADDR0 12'h3B0
`define PMP_CSR_MSECCFG  12'h747

// Rule-locking bypass bit in mseccfg
`define PMP_RLB_BIT 2

`endif

// File: hw/pmp_checker.sv
// Combinational PMP permission check of one access against all regions
// Lowest-index matching region decides; no match allows M-mode only

`timescale 1ns/1ps
`default_nettype none

`include "pmp_cfg.svh"

module pmp_checker (
  input  wire pmp_pkg::pmp_regs_t   regs_i,
  input  wire pmp_pkg::priv_e       priv_i,
  input  wire pmp_pkg::pmp_access_t acc_i,
  output logic                      allow_o
);

  localparam int num_regions = `PMP_NUM_REGIONS;

  logic [31:0]            word_addr;
  logic                   is_m;
  logic [num_regions-1:0] match;
  logic [num_regions-1:0] perm;

  // Word address widened to the pmpaddr format
  assign word_addr = {2'b00, acc_i.addr[31:2]};
  assign is_m      = priv_i == pmp_pkg::PRIV_M;

  for (genvar i = 0; i < num_regions; i++) begin : gen_region
    logic [31:0] lo_bound;
    logic [31:0] napot_care;
    logic        tor_hit;
    logic        na4_hit;
    logic        napot_hit;
    logic        kind_ok;

    if (i == 0) begin : gen_first
      assign lo_bound = '0;
    end else begin : gen_rest
      assign lo_bound = regs_i.addr[i-1];
    end

    // Trailing ones plus the next zero bit are don't-care
    assign napot_care = ~(regs_i.addr[i] ^ (regs_i.addr[i] + 32'd1));

    assign tor_hit   = (word_addr >= lo_bound) && (word_addr < regs_i.addr[i]);
    assign na4_hit   = word_addr == regs_i.addr[i];
    assign napot_hit = ((word_addr ^ regs_i.addr[i]) & napot_care) == '0;

    assign match[i] = ((regs_i.cfg[i].mode == pmp_pkg::PMP_TOR)   && tor_hit) ||
                      ((regs_i.cfg[i].mode == pmp_pkg::PMP_NA4)   && na4_hit) ||
                      ((regs_i.cfg[i].mode == pmp_pkg::PMP_NAPOT) && napot_hit);

    assign kind_ok = ((acc_i.kind == pmp_pkg::ACC_READ)  && regs_i.cfg[i].r) ||
                     ((acc_i.kind == pmp_pkg::ACC_WRITE) && regs_i.cfg[i].w) ||
                     ((acc_i.kind == pmp_pkg::ACC_EXEC)  && regs_i.cfg[i].x);

    // Unlocked entries do not restrict M-mode
    assign perm[i] = (is_m && !regs_i.cfg[i].lock) || kind_ok;
  end

  // Walk down so the lowest matching index is applied last
  always_comb begin
    allow_o = is_m;
    for (int i = num_regions - 1; i >= 0; i--) begin
      if (match[i]) begin
        allow_o = perm[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/pmp_csr_file.sv
// PMP configuration, address and mseccfg.RLB registers with their WARL write rules
// Serves CSR reads combinationally; writes land on the next rising edge

`timescale 1ns/1ps
`default_nettype none

`include "pmp_cfg.svh"

module pmp_csr_file (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  wire pmp_pkg::csr_req_t    csr_req_i,
  input  wire pmp_pkg::priv_e       priv_i,
  output logic [31:0]               csr_rdata_o,
  output logic                      csr_err_o,
  output pmp_pkg::pmp_regs_t        regs_o
);

  localparam int num_regions = `PMP_NUM_REGIONS;
  localparam int cfg_idx_w   = $clog2(`PMP_NUM_CFG_WORDS);
  localparam int addr_idx_w  = $clog2(`PMP_NUM_REGIONS);

  pmp_pkg::pmp_regs_t     regs_q;
  pmp_pkg::pmp_regs_t     regs_d;
  pmp_pkg::pmpcfg_word_u  wr_word;
  pmp_pkg::pmpcfg_word_u  rd_word;

  logic [11:0]            cfg_off;
  logic [11:0]            addr_off;
  logic [cfg_idx_w-1:0]   cfg_sel;
  logic [addr_idx_w-1:0]  addr_sel;
  logic                   is_cfg;
  logic                   is_addr;
  logic                   is_msec;
  logic                   accept;
  logic                   wr_en;
  logic [num_regions-1:0] lock_vec;
  logic [num_regions-1:0] addr_frozen;

  // Locked bytes keep their value, W without R keeps the old RWX
  function automatic pmp_pkg::pmp_entry_cfg_t legal_cfg(
    input pmp_pkg::pmp_entry_cfg_t old_cfg,
    input pmp_pkg::pmp_entry_cfg_t new_cfg,
    input logic                    rlb
  );
    pmp_pkg::pmp_entry_cfg_t res;
    res = new_cfg;
    res.zero = 2'b00;
    if ({new_cfg.x, new_cfg.w, new_cfg.r} inside {3'd2, 3'd6}) begin
      {res.x, res.w, res.r} = {old_cfg.x, old_cfg.w, old_cfg.r};
    end
    if (old_cfg.lock && !rlb) begin
      res = old_cfg;
    end
    return res;
  endfunction

  // Address decode
  assign cfg_off  = csr_req_i.addr - `PMP_CSR_PMPCFG0;
  assign addr_off = csr_req_i.addr - `PMP_CSR_PMPADDR0;
  assign cfg_sel  = cfg_off[cfg_idx_w-1:0];
  assign addr_sel = addr_off[addr_idx_w-1:0];
  assign is_cfg   = cfg_off < 12'(`PMP_NUM_CFG_WORDS);
  assign is_addr  = addr_off < 12'(`PMP_NUM_REGIONS);
  assign is_msec  = csr_req_i.addr == `PMP_CSR_MSECCFG;

  // Only M-mode may touch the PMP CSRs
  assign csr_err_o = csr_req_i.valid &&
                     ((priv_i != pmp_pkg::PRIV_M) || !(is_cfg || is_addr || is_msec));
  assign accept    = csr_req_i.valid && !csr_err_o;
  assign wr_en     = accept && csr_req_i.write;

  assign wr_word.raw = csr_req_i.wdata;

  for (genvar i = 0; i < num_regions; i++) begin : gen_lock
    assign lock_vec[i] = regs_q.cfg[i].lock;
    // A locked TOR entry also pins the base address below it
    if (i < num_regions - 1) begin : gen_below_tor
      assign addr_frozen[i] = !regs_q.rlb &&
                              (regs_q.cfg[i].lock ||
                               (regs_q.cfg[i+1].lock &&
                                (regs_q.cfg[i+1].mode == pmp_pkg::PMP_TOR)));
    end else begin : gen_top
      assign addr_frozen[i] = !regs_q.rlb && regs_q.cfg[i].lock;
    end
  end

  // Next state for an accepted write
  always_comb begin
    regs_d = regs_q;
    for (int i = 0; i < num_regions; i++) begin
      if (is_cfg && (cfg_sel == cfg_idx_w'(i / 4))) begin
        regs_d.cfg[i] = legal_cfg(regs_q.cfg[i], wr_word.entry[i % 4], regs_q.rlb);
      end
      if (is_addr && (addr_sel == addr_idx_w'(i)) && !addr_frozen[i]) begin
        regs_d.addr[i] = csr_req_i.wdata;
      end
    end
    // RLB cannot be raised again once an entry is locked
    if (is_msec) begin
      if (!(csr_req_i.wdata[`PMP_RLB_BIT] && !regs_q.rlb && (|lock_vec))) begin
        regs_d.rlb = csr_req_i.wdata[`PMP_RLB_BIT];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '0;
    end else if (wr_en) begin
      regs_q <= regs_d;
    end
  end

  // Read data shows the value held before this cycle's write
  always_comb begin
    rd_word = '0;
    csr_rdata_o = '0;
    for (int i = 0; i < num_regions; i++) begin
      if (cfg_sel == cfg_idx_w'(i / 4)) begin
        rd_word.entry[i % 4] = regs_q.cfg[i];
      end
    end
    if (accept) begin
      if (is_cfg) begin
        csr_rdata_o = rd_word.raw;
      end else if (is_addr) begin
        csr_rdata_o = regs_q.addr[addr_sel];
      end else if (is_msec) begin
        csr_rdata_o[`PMP_RLB_BIT] = regs_q.rlb;
      end
    end
  end

  assign regs_o = regs_q;

endmodule

`default_nettype wire

// File: hw/pmp_pkg.sv
// Shared types of the PMP unit: privilege, entry config, CSR request and access
// Referenced by scoped name from the RTL and the testbench

`default_nettype none

`include "pmp_cfg.svh"

package pmp_pkg;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_e;

  typedef enum logic [1:0] {
    PMP_OFF   = 2'd0,
    PMP_TOR   = 2'd1,
    PMP_NA4   = 2'd2,
    PMP_NAPOT = 2'd3
  } pmp_mode_e;

  typedef enum logic [1:0] {
    ACC_READ  = 2'd0,
    ACC_WRITE = 2'd1,
    ACC_EXEC  = 2'd2
  } acc_kind_e;

  // One pmpNcfg byte, L in bit 7 down to R in bit 0
  typedef struct packed {
    logic       lock;
    logic [1:0] zero;
    pmp_mode_e  mode;
    logic       x;
    logic       w;
    logic       r;
  } pmp_entry_cfg_t;

  // A pmpcfg CSR seen whole or as its four entry bytes
  typedef union packed {
    logic [31:0]          raw;
    pmp_entry_cfg_t [3:0] entry;
  } pmpcfg_word_u;

  // Full architectural state, pmpaddr holds physical address bits 33:2
  typedef struct packed {
    pmp_entry_cfg_t [`PMP_NUM_REGIONS-1:0]      cfg;
    logic [`PMP_NUM_REGIONS-1:0][31:0]          addr;
    logic                                       rlb;
  } pmp_regs_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [11:0] addr;
    logic [31:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic [31:0] addr;
    acc_kind_e   kind;
  } pmp_access_t;

endpackage

`default_nettype wire

// File: hw/pmp_unit.sv
// PMP unit top: CSR register file feeding the access checker
// CSR writes land on the next edge, access checks are combinational

`timescale 1ns/1ps
`default_nettype none

module pmp_unit (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  wire pmp_pkg::csr_req_t    csr_req_i,
  input  wire pmp_pkg::priv_e       priv_i,
  input  wire pmp_pkg::pmp_access_t acc_i,
  output logic [31:0]               csr_rdata_o,
  output logic                      csr_err_o,
  output logic                      acc_allow_o
);

  // Stored PMP state shared by both halves
  pmp_pkg::pmp_regs_t regs;

  pmp_csr_file csr_file_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr_req_i   (csr_req_i),
    .priv_i      (priv_i),
    .csr_rdata_o (csr_rdata_o),
    .csr_err_o   (csr_err_o),
    .regs_o      (regs)
  );

  pmp_checker checker_inst (
    .regs_i  (regs),
    .priv_i  (priv_i),
    .acc_i   (acc_i),
    .allow_o (acc_allow_o)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the PMP testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module pmp_tb \
  --Mdir obj_dir -o pmp_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/pmp_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qxF "Simulation completed successfully"; then
  exit 0
fi
exit 1

// File: sim.f
+incdir+hw
hw/pmp_pkg.sv
hw/pmp_csr_file.sv
hw/pmp_checker.sv
hw/pmp_unit.sv
verif/pmp_clkgen.sv
verif/pmp_chk.sv
verif/pmp_tb.sv

// File: verif/pmp_chk.sv
// Concurrent assertions on the PMP CSR file state
// Bound into pmp_csr_file from the testbench

`timescale 1ns/1ps
`default_nettype none

`include "pmp_cfg.svh"

module pmp_chk (
  input wire                     clk_i,
  input wire                     rst_ni,
  input wire                     csr_err_i,
  input wire pmp_pkg::pmp_regs_t regs_i
);

  // Refused requests leave the state alone
  a_refused_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    csr_err_i |=> $stable(regs_i)
  ) else $error("State changed after a refused CSR request");

  for (genvar i = 0; i < `PMP_NUM_REGIONS; i++) begin : gen_entry
    a_lock_held: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (regs_i.cfg[i].lock && !regs_i.rlb) |=> regs_i.cfg[i].lock
    ) else $error("Entry %0d lost its lock while RLB was clear", i);

    // Reserved RWX encodings never reach the register
    a_rwx_legal: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      ({regs_i.cfg[i].x, regs_i.cfg[i].w, regs_i.cfg[i].r} != 3'd2) &&
      ({regs_i.cfg[i].x, regs_i.cfg[i].w, regs_i.cfg[i].r} != 3'd6)
    ) else $error("Entry %0d holds a reserved RWX value", i);

    a_zero_bits: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      regs_i.cfg[i].zero == 2'b00
    ) else $error("Entry %0d has bits 6:5 set", i);
  end

endmodule

`default_nettype wire

// File: verif/pmp_clkgen.sv
// Testbench clock and reset source: 100 ns clock, reset low for two cycles

`timescale 1ns/1ps
`default_nettype none

module pmp_clkgen (
  output logic clk_o,
  output logic rst_no
);

  localparam time half_period = 50ns;

  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = ~clk_o;
  end

  // Release a little after the second rising edge
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #10ns;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: verif/pmp_tb.sv
// Testbench for the PMP unit: directed and LFSR-driven stimulus against a reference model
// Inputs change on the falling edge, outputs are compared mid-cycle

`timescale 1ns/1ps
`default_nettype none

`include "pmp_cfg.svh"

module pmp_tb;

  localparam int          reset_timeout = 10;
  localparam int          random_cycles = 400;
  localparam logic [15:0] lfsr_seed     = 16'd57015;

  logic                 clk;
  logic                 rst_n;
  pmp_pkg::csr_req_t    csr_req;
  pmp_pkg::priv_e       priv;
  pmp_pkg::pmp_access_t acc;
  logic [31:0]          csr_rdata;
  logic                 csr_err;
  logic                 acc_allow;
  pmp_pkg::pmp_regs_t   shadow;
  logic [15:0]          lfsr_q;
  string                test_name;
  int                   error_count;

  pmp_clkgen clkgen_inst (.clk_o(clk), .rst_no(rst_n));

  pmp_unit pmp_unit_inst (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .csr_req_i   (csr_req),
    .priv_i      (priv),
    .acc_i       (acc),
    .csr_rdata_o (csr_rdata),
    .csr_err_o   (csr_err),
    .acc_allow_o (acc_allow)
  );

  bind pmp_csr_file pmp_chk chk_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .csr_err_i (csr_err_o),
    .regs_i    (regs_o)
  );

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic region_hit(input pmp_pkg::pmp_regs_t s, input int i,
                                      input logic [31:0] waddr);
    logic [31:0] lo;
    logic [31:0] pa;
    int          ones;
    pa = s.addr[i];
    lo = '0;
    if (i > 0) begin
      lo = s.addr[i-1];
    end
    ones = 0;
    while (ones < 32 && pa[ones]) begin
      ones++;
    end
    case (s.cfg[i].mode)
      pmp_pkg::PMP_TOR:   return (waddr >= lo) && (waddr < pa);
      pmp_pkg::PMP_NA4:   return waddr == pa;
      // NAPOT covers 2^(ones+1) words
      pmp_pkg::PMP_NAPOT: return (waddr >> (ones + 1)) == (pa >> (ones + 1));
      default:            return 1'b0;
    endcase
  endfunction

  // Shadow state after the request of this cycle
  function automatic pmp_pkg::pmp_regs_t ref_write(input pmp_pkg::pmp_regs_t s,
                                                   input pmp_pkg::csr_req_t req,
                                                   input pmp_pkg::priv_e p);
    pmp_pkg::pmp_regs_t      n;
    pmp_pkg::pmp_entry_cfg_t b;
    logic                    any_lock;
    logic                    frozen;
    int                      idx;
    n = s;
    any_lock = 1'b0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      any_lock = any_lock | s.cfg[i].lock;
    end
    if (req.valid && req.write && p == pmp_pkg::PRIV_M) begin
      if (req.addr == `PMP_CSR_PMPCFG0 || req.addr == `PMP_CSR_PMPCFG0 + 12'd1) begin
        for (int j = 0; j < 4; j++) begin
          idx = int'(req.addr - `PMP_CSR_PMPCFG0) * 4 + j;
          b = req.wdata[8*j +: 8];
          if (!(s.cfg[idx].lock && !s.rlb)) begin
            n.cfg[idx] = b;
            n.cfg[idx].zero = 2'b00;
            if (b[2:0] == 3'd2 || b[2:0] == 3'd6) begin
              {n.cfg[idx].x, n.cfg[idx].w, n.cfg[idx].r} =
                {s.cfg[idx].x, s.cfg[idx].w, s.cfg[idx].r};
            end
          end
        end
      end else if (req.addr >= `PMP_CSR_PMPADDR0 &&
                   req.addr < `PMP_CSR_PMPADDR0 + 12'd8) begin
        idx = int'(req.addr - `PMP_CSR_PMPADDR0);
        frozen = s.cfg[idx].lock;
        if (idx < `PMP_NUM_REGIONS - 1) begin
          if (s.cfg[idx+1].lock && s.cfg[idx+1].mode == pmp_pkg::PMP_TOR) begin
            frozen = 1'b1;
          end
        end
        if (!(frozen && !s.rlb)) begin
          n.addr[idx] = req.wdata;
        end
      end else if (req.addr == `PMP_CSR_MSECCFG) begin
        if (!(req.wdata[`PMP_RLB_BIT] && !s.rlb && any_lock)) begin
          n.rlb = req.wdata[`PMP_RLB_BIT];
        end
      end
    end
    return n;
  endfunction

  // Expected {csr_err, csr_rdata, acc_allow} for the current inputs
  function automatic logic [33:0] ref_expect(input pmp_pkg::pmp_regs_t s,
                                             input pmp_pkg::csr_req_t req,
                                             input pmp_pkg::priv_e p,
                                             input pmp_pkg::pmp_access_t a);
    logic        is_cfg;
    logic        is_addr;
    logic        known;
    logic        err;
    logic        allow;
    logic        decided;
    logic        kind_bit;
    logic [31:0] rdata;
    int          base;
    is_cfg  = req.addr == `PMP_CSR_PMPCFG0 || req.addr == `PMP_CSR_PMPCFG0 + 12'd1;
    is_addr = req.addr >= `PMP_CSR_PMPADDR0 && req.addr < `PMP_CSR_PMPADDR0 + 12'd8;
    known   = is_cfg || is_addr || req.addr == `PMP_CSR_MSECCFG;
    err     = req.valid && (p != pmp_pkg::PRIV_M || !known);
    rdata   = '0;
    if (req.valid && !err) begin
      if (is_cfg) begin
        base = int'(req.addr - `PMP_CSR_PMPCFG0) * 4;
        for (int j = 0; j < 4; j++) begin
          rdata[8*j +: 8] = s.cfg[base + j];
        end
      end else if (is_addr) begin
        rdata = s.addr[int'(req.addr - `PMP_CSR_PMPADDR0)];
      end else begin
        rdata[`PMP_RLB_BIT] = s.rlb;
      end
    end
    allow   = p == pmp_pkg::PRIV_M;
    decided = 1'b0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      if (!decided && region_hit(s, i, {2'b00, a.addr[31:2]})) begin
        decided  = 1'b1;
        kind_bit = (a.kind == pmp_pkg::ACC_READ)  ? s.cfg[i].r :
                   (a.kind == pmp_pkg::ACC_WRITE) ? s.cfg[i].w : s.cfg[i].x;
        allow = (p == pmp_pkg::PRIV_M && !s.cfg[i].lock) || kind_bit;
      end
    end
    return {err, rdata, allow};
  endfunction

  task automatic compare_values(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
    if (exp !== act) begin
      error_count++;
      $display("MISMATCH test=%s %s expected=0x%08h actual=0x%08h",
               test_name, what, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > reset_timeout) begin
        $display("Timeout: reset was never released");
        $display("Simulation failed");
        $fatal(1);
      end
    end
  endtask

  task automatic drive(input logic valid, input logic write, input logic [11:0] addr,
                       input logic [31:0] wdata, input pmp_pkg::priv_e p,
                       input logic [31:0] aaddr, input pmp_pkg::acc_kind_e kind);
    @(negedge clk);
    csr_req  = '{valid: valid, write: write, addr: addr, wdata: wdata};
    priv     = p;
    acc.addr = aaddr;
    acc.kind = kind;
  endtask

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] wdata,
                           input pmp_pkg::priv_e p);
    drive(1'b1, 1'b1, addr, wdata, p, 32'h0, pmp_pkg::ACC_READ);
  endtask

  task automatic read_expect(input logic [11:0] addr, input logic [31:0] exp);
    drive(1'b1, 1'b0, addr, 32'h0, pmp_pkg::PRIV_M, 32'h0, pmp_pkg::ACC_READ);
    #25ns;
    compare_values($sformatf("rdata[%h]", addr), exp, csr_rdata);
  endtask

  task automatic access_expect(input logic [31:0] aaddr, input pmp_pkg::acc_kind_e kind,
                               input pmp_pkg::priv_e p, input logic exp);
    drive(1'b0, 1'b0, 12'h0, 32'h0, p, aaddr, kind);
    #25ns;
    compare_values($sformatf("allow[%h %s]", aaddr, kind.name()), 32'(exp), 32'(acc_allow));
  endtask

  // Model check on every cycle, then advance the shadow state
  initial begin : compare_proc
    logic [33:0] expected;
    wait_reset_release();
    forever begin
      @(negedge clk);
      #25ns;
      expected = ref_expect(shadow, csr_req, priv, acc);
      compare_values("csr_err", 32'(expected[33]), 32'(csr_err));
      compare_values("csr_rdata", expected[32:1], csr_rdata);
      compare_values("acc_allow", 32'(expected[0]), 32'(acc_allow));
      shadow = ref_write(shadow, csr_req, priv);
    end
  end

  initial begin : stimulus_proc
    logic [11:0] addr_pick [12];
    logic [31:0] wdata;
    logic [3:0]  pick;
    logic [1:0]  op;
    csr_req     = '0;
    priv        = pmp_pkg::PRIV_M;
    acc         = '0;
    shadow      = '0;
    lfsr_q      = lfsr_seed;
    error_count = 0;
    test_name   = "reset";
    wait_reset_release();

    for (int i = 0; i < 2; i++) begin
      read_expect(`PMP_CSR_PMPCFG0 + 12'(i), 32'h0);
    end
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      read_expect(`PMP_CSR_PMPADDR0 + 12'(i), 32'h0);
    end
    read_expect(`PMP_CSR_MSECCFG, 32'h0);
    access_expect(32'h1000, pmp_pkg::ACC_READ,  pmp_pkg::PRIV_M, 1'b1);
    access_expect(32'h1000, pmp_pkg::ACC_WRITE, pmp_pkg::PRIV_M, 1'b1);
    access_expect(32'h1000, pmp_pkg::ACC_EXEC,  pmp_pkg::PRIV_M, 1'b1);
    access_expect(32'h1000, pmp_pkg::ACC_READ,  pmp_pkg::PRIV_U, 1'b0);
    access_expect(32'h1000, pmp_pkg::ACC_WRITE, pmp_pkg::PRIV_U, 1'b0);
    access_expect(32'h1000, pmp_pkg::ACC_EXEC,  pmp_pkg::PRIV_U, 1'b0);

    test_name = "csr_write";
    csr_write(`PMP_CSR_PMPCFG0, 32'h0000_0003, pmp_pkg::PRIV_M);
    // Bits 6:5 set and RWX 6 on top of RW
    csr_write(`PMP_CSR_PMPCFG0, 32'h0000_0066, pmp_pkg::PRIV_M);
    read_expect(`PMP_CSR_PMPCFG0, 32'h0000_0003);
    csr_write(`PMP_CSR_PMPCFG0, 32'h0000_0002, pmp_pkg::PRIV_M);
    read_expect(`PMP_CSR_PMPCFG0, 32'h0000_0003);
    csr_write(`PMP_CSR_PMPCFG0, 32'h0000_00FF, pmp_pkg::PRIV_U);
    csr_write(12'h3A2, 32'hFFFF_FFFF, pmp_pkg::PRIV_M);
    read_expect(`PMP_CSR_PMPCFG0, 32'h0000_0003);

    test_name = "matching";
    csr_write(`PMP_CSR_PMPADDR0,          32'h0000_0100, pmp_pkg::PRIV_M);
    csr_write(`PMP_CSR_PMPADDR0 + 12'd1, 32'h0000_0100, pmp_pkg::PRIV_M);
    csr_write(`PMP_CSR_PMPADDR0 + 12'd2, 32'h0000_0203, pmp_pkg::PRIV_M);
    csr_write(`PMP_CSR_PMPADDR0 + 12'd3, 32'h0000_027F, pmp_pkg::PRIV_M);
    // TOR r, NA4 rw, NAPOT rx, NAPOT rw
    csr_write(`PMP_CSR_PMPCFG0, 32'h1B1D_1309, pmp_pkg::PRIV_M);
    read_expect(`PMP_CSR_PMPCFG0, 32'h1B1D_1309);
    access_expect(32'h0000_0100, pmp_pkg::ACC_READ,  pmp_pkg::PRIV_U, 1'b1);
    access_expect(32'h0000_0100, pmp_pkg::ACC_WRITE, pmp_pkg::PRIV_U, 1'b0);
    access_expect(32'h0000_0400, pmp_pkg::ACC_WRITE, pmp_pkg::PRIV_U, 1'b1);
    access_expect(32'h0000_0400, pmp_pkg::ACC_EXEC,  pmp_pkg::PRIV_U, 1'b0);
    access_expect(32'h0000_0804, pmp_pkg::ACC_EXEC,  pmp_pkg::PRIV_U, 1'b1);
    access_expect(32'h0000_0804, pmp_pkg::ACC_WRITE, pmp_pkg::PRIV_U, 1'b0);
    access_expect(32'h0000_0900, pmp_pkg::ACC_WRITE, pmp_pkg::PRIV_U, 1'b1);
    access_expect(32'h0000_0900, pmp_pkg::ACC_EXEC,  pmp_pkg::PRIV_U, 1'b0);
    access_expect(32'h0000_2000, pmp_pkg::ACC_READ,  pmp_pkg::PRIV_U, 1'b0);
    access_expect(32'h0000_2000, pmp_pkg::ACC_READ,  pmp_pkg::PRIV_M, 1'b1);

    test_name = "rlb";
    csr_write(`PMP_CSR_MSECCFG, 32'h0000_0004, pmp_pkg::PRIV_M);
    read_expect(`PMP_CSR_MSECCFG, 32'h0000_0004);
    csr_write(`PMP_CSR_PMPCFG0 + 12'd1, 32'h0, pmp_pkg::PRIV_M);
    csr_write(`PMP_CSR_PMPCFG0 + 12'd1, 32'h0000_0089, pmp_pkg::PRIV_M);
    csr_write(`PMP_CSR_PMPCFG0 + 12'd1, 32'h0000_0003, pmp_pkg::PRIV_M);
    read_expect(`PMP_CSR_PMPCFG0 + 12'd1, 32'h0000_0003);
    csr_write(`PMP_CSR_PMPCFG0 + 12'd1, 32'h0000_0089, pmp_pkg::PRIV_M);
    csr_write(`PMP_CSR_PMPADDR0 + 12'd4, 32'h0000_1000, pmp_pkg::PRIV_M);
    read_expect(`PMP_CSR_PMPADDR0 + 12'd4, 32'h0000_1000);
    csr_write(`PMP_CSR_MSECCFG, 32'h0000_0000, pmp_pkg::PRIV_M);
    csr_write(`PMP_CSR_MSECCFG, 32'h0000_0004, pmp_pkg::PRIV_M);
    read_expect(`PMP_CSR_MSECCFG, 32'h0000_0000);

    test_name = "locking";
    csr_write(`PMP_CSR_PMPCFG0 + 12'd1, 32'h0000_0000, pmp_pkg::PRIV_M);
    read_expect(`PMP_CSR_PMPCFG0 + 12'd1, 32'h0000_0089);
    csr_write(`PMP_CSR_PMPADDR0 + 12'd4, 32'h0000_5000, pmp_pkg::PRIV_M);
    read_expect(`PMP_CSR_PMPADDR0 + 12'd4, 32'h0000_1000);
    // Base of the locked TOR region
    csr_write(`PMP_CSR_PMPADDR0 + 12'd3, 32'h0000_0000, pmp_pkg::PRIV_M);
    read_expect(`PMP_CSR_PMPADDR0 + 12'd3, 32'h0000_027F);
    access_expect(32'h0000_2000, pmp_pkg::ACC_READ,  pmp_pkg::PRIV_M, 1'b1);
    access_expect(32'h0000_2000, pmp_pkg::ACC_WRITE, pmp_pkg::PRIV_M, 1'b0);
    access_expect(32'h0000_2000, pmp_pkg::ACC_EXEC,  pmp_pkg::PRIV_M, 1'b0);

    test_name = "random";
    addr_pick[0]  = `PMP_CSR_PMPCFG0;
    addr_pick[1]  = `PMP_CSR_PMPCFG0 + 12'd1;
    addr_pick[10] = `PMP_CSR_MSECCFG;
    addr_pick[11] = 12'h3A2;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      addr_pick[i + 2] = `PMP_CSR_PMPADDR0 + 12'(i);
    end
    for (int c = 0; c < random_cycles; c++) begin
      op    = 2'(rand_bits(2));
      pick  = 4'(rand_bits(4));
      wdata = (rand_bits(1) != 32'd0) ? rand_bits(12) : rand_bits(32);
      drive(op != 2'd3, op == 2'd0, addr_pick[pick % 12], wdata,
            (rand_bits(2) == 32'd0) ? pmp_pkg::PRIV_U : pmp_pkg::PRIV_M,
            rand_bits(14),
            (rand_bits(1) != 32'd0) ? pmp_pkg::ACC_EXEC :
            (rand_bits(1) != 32'd0) ? pmp_pkg::ACC_WRITE : pmp_pkg::ACC_READ);
    end

    drive(1'b0, 1'b0, 12'h0, 32'h0, pmp_pkg::PRIV_M, 32'h0, pmp_pkg::ACC_READ);
    #30ns;
    if (error_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire
